// File: rtl/mipsIsa_pkg.sv
`default_nettype none

package mipsIsa_pkg;

	// ==============================
	// basic types
	// ==============================

	// data and address word
	typedef logic [31:0] word_t;
	// gpr number
	typedef logic [4:0] regAddr_t;

	// ==============================
	// primary opcodes
	// ==============================

	// r-type group, op selected by funct
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLui     = 6'h0f;
	// loads
	localparam logic [5:0] opLb      = 6'h20;
	localparam logic [5:0] opLh      = 6'h21;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opLbu     = 6'h24;
	localparam logic [5:0] opLhu     = 6'h25;
	// stores
	localparam logic [5:0] opSb      = 6'h28;
	localparam logic [5:0] opSh      = 6'h29;
	localparam logic [5:0] opSw      = 6'h2b;

	// funct codes under opSpecial
	localparam logic [5:0] fnSll     = 6'h00;
	localparam logic [5:0] fnAddu    = 6'h21;
	localparam logic [5:0] fnSubu    = 6'h23;
	localparam logic [5:0] fnAnd     = 6'h24;
	localparam logic [5:0] fnOr      = 6'h25;
	localparam logic [5:0] fnXor     = 6'h26;
	localparam logic [5:0] fnSlt     = 6'h2a;

	// first fetch address out of reset
	localparam word_t resetVector = 32'h0000_0000;

endpackage

`default_nettype wire

// File: rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// ==============================
	// control encodings
	// ==============================

	// zero value is add so a bubble computes harmlessly
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluLui
	} aluOp_t;

	// memory access width
	// memNone for non-memory ops
	typedef enum logic [1:0] {
		memNone, memByte, memHalf, memWord
	} memWidth_t;

	// execute operand source
	// register value unless a younger stage holds the result
	localparam logic [1:0] fwdNone = 2'b00;
	localparam logic [1:0] fwdWb   = 2'b01;
	localparam logic [1:0] fwdMem  = 2'b10;

	// ==============================
	// stage payloads
	// ==============================

	// fetch to decode
	typedef struct packed {
		mipsIsa_pkg::word_t instr;
		mipsIsa_pkg::word_t pc;
	} fetchToDec_t;

	// decode to execute
	typedef struct packed {
		mipsIsa_pkg::word_t    opA;
		mipsIsa_pkg::word_t    opB;
		mipsIsa_pkg::word_t    imm;
		logic [4:0]            shamt;
		mipsIsa_pkg::regAddr_t rs;
		mipsIsa_pkg::regAddr_t rt;
		mipsIsa_pkg::regAddr_t dest;
		aluOp_t                aluOp;
		logic                  immSel;
		logic                  regWrite;
		memWidth_t             loadWidth;
		logic                  loadSigned;
		memWidth_t             storeWidth;
		mipsIsa_pkg::word_t    pc;
	} decToExec_t;

	// execute to memory
	typedef struct packed {
		mipsIsa_pkg::word_t    aluResult;
		mipsIsa_pkg::word_t    storeData;
		mipsIsa_pkg::regAddr_t dest;
		logic                  regWrite;
		memWidth_t             loadWidth;
		logic                  loadSigned;
		memWidth_t             storeWidth;
		mipsIsa_pkg::word_t    pc;
	} execToMem_t;

	// memory to writeback
	typedef struct packed {
		mipsIsa_pkg::word_t    aluResult;
		mipsIsa_pkg::word_t    rdData;
		mipsIsa_pkg::regAddr_t dest;
		logic                  regWrite;
		memWidth_t             loadWidth;
		logic                  loadSigned;
		mipsIsa_pkg::word_t    pc;
	} memToWb_t;

endpackage

`default_nettype wire

// File: rtl/stageReg.sv
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     arstN,
	input  logic     en,
	input  logic     clr,
	input  payload_t d,
	output payload_t q
);

	// all zeros is a bubble
	// clear wins over enable so a stalled slot can still be flushed
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end else if (clr) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic                  clk,
	input  logic                  arstN,
	input  mipsIsa_pkg::regAddr_t rdAddrA,
	input  mipsIsa_pkg::regAddr_t rdAddrB,
	output mipsIsa_pkg::word_t    rdDataA,
	output mipsIsa_pkg::word_t    rdDataB,
	input  logic                  wrEn,
	input  mipsIsa_pkg::regAddr_t wrAddr,
	input  mipsIsa_pkg::word_t    wrData
);

	// r0 has no storage
	mipsIsa_pkg::word_t regs [1:31];

	// gprs start from zero
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// r0 reads zero
	// writeback data bypassed when decode reads the reg being written
	assign rdDataA = (rdAddrA == '0) ? '0 :
		(wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 :
		(wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

// File: rtl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  mipsIsa_pkg::word_t   instr,
	output pipe_pkg::decToExec_t ctrl
);

	logic [5:0]            opcode;
	logic [5:0]            funct;
	mipsIsa_pkg::regAddr_t rs;
	mipsIsa_pkg::regAddr_t rt;
	mipsIsa_pkg::regAddr_t rd;
	mipsIsa_pkg::word_t    immSext;
	mipsIsa_pkg::word_t    immZext;
	logic                  known;

	// instruction fields
	assign opcode  = instr[31:26];
	assign funct   = instr[5:0];
	assign rs      = instr[25:21];
	assign rt      = instr[20:16];
	assign rd      = instr[15:11];
	assign immSext = {{16{instr[15]}}, instr[15:0]};
	assign immZext = {16'h0000, instr[15:0]};

	always_comb begin
		ctrl  = '0;
		known = 1'b1;
		// ==============================
		// op class
		// ==============================
		// rs and rt only filled when really read, keeps load-use stalls exact
		case (opcode)
			mipsIsa_pkg::opSpecial: begin
				ctrl.rs       = rs;
				ctrl.rt       = rt;
				ctrl.dest     = rd;
				ctrl.regWrite = 1'b1;
				ctrl.shamt    = instr[10:6];
				case (funct)
					mipsIsa_pkg::fnAddu: ctrl.aluOp = pipe_pkg::aluAdd;
					mipsIsa_pkg::fnSubu: ctrl.aluOp = pipe_pkg::aluSub;
					mipsIsa_pkg::fnAnd:  ctrl.aluOp = pipe_pkg::aluAnd;
					mipsIsa_pkg::fnOr:   ctrl.aluOp = pipe_pkg::aluOr;
					mipsIsa_pkg::fnXor:  ctrl.aluOp = pipe_pkg::aluXor;
					mipsIsa_pkg::fnSlt:  ctrl.aluOp = pipe_pkg::aluSlt;
					mipsIsa_pkg::fnSll: begin
						// shifts rt, rs unused
						ctrl.aluOp = pipe_pkg::aluSll;
						ctrl.rs    = '0;
					end
					default: known = 1'b0;
				endcase
			end
			mipsIsa_pkg::opAddiu: begin
				ctrl.rs       = rs;
				ctrl.dest     = rt;
				ctrl.regWrite = 1'b1;
				ctrl.immSel   = 1'b1;
				ctrl.imm      = immSext;
			end
			mipsIsa_pkg::opOri: begin
				ctrl.rs       = rs;
				ctrl.dest     = rt;
				ctrl.regWrite = 1'b1;
				ctrl.immSel   = 1'b1;
				ctrl.imm      = immZext;
				ctrl.aluOp    = pipe_pkg::aluOr;
			end
			mipsIsa_pkg::opLui: begin
				// no register source
				ctrl.dest     = rt;
				ctrl.regWrite = 1'b1;
				ctrl.immSel   = 1'b1;
				ctrl.imm      = immZext;
				ctrl.aluOp    = pipe_pkg::aluLui;
			end
			mipsIsa_pkg::opLb, mipsIsa_pkg::opLbu, mipsIsa_pkg::opLh,
			mipsIsa_pkg::opLhu, mipsIsa_pkg::opLw: begin
				// address is base plus signed offset
				ctrl.rs       = rs;
				ctrl.dest     = rt;
				ctrl.regWrite = 1'b1;
				ctrl.immSel   = 1'b1;
				ctrl.imm      = immSext;
			end
			mipsIsa_pkg::opSb, mipsIsa_pkg::opSh, mipsIsa_pkg::opSw: begin
				// rt carries store data
				ctrl.rs     = rs;
				ctrl.rt     = rt;
				ctrl.immSel = 1'b1;
				ctrl.imm    = immSext;
			end
			default: known = 1'b0;
		endcase
		// ==============================
		// access width
		// ==============================
		case (opcode)
			mipsIsa_pkg::opLb: begin
				ctrl.loadWidth  = pipe_pkg::memByte;
				ctrl.loadSigned = 1'b1;
			end
			mipsIsa_pkg::opLh: begin
				ctrl.loadWidth  = pipe_pkg::memHalf;
				ctrl.loadSigned = 1'b1;
			end
			mipsIsa_pkg::opLbu: ctrl.loadWidth  = pipe_pkg::memByte;
			mipsIsa_pkg::opLhu: ctrl.loadWidth  = pipe_pkg::memHalf;
			mipsIsa_pkg::opLw:  ctrl.loadWidth  = pipe_pkg::memWord;
			mipsIsa_pkg::opSb:  ctrl.storeWidth = pipe_pkg::memByte;
			mipsIsa_pkg::opSh:  ctrl.storeWidth = pipe_pkg::memHalf;
			mipsIsa_pkg::opSw:  ctrl.storeWidth = pipe_pkg::memWord;
			default: ;
		endcase
		// unsupported encoding becomes a bubble
		if (!known) begin
			ctrl = '0;
		end
		// never retire a write to r0
		if (ctrl.dest == '0) begin
			ctrl.regWrite = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  pipe_pkg::aluOp_t   op,
	input  mipsIsa_pkg::word_t a,
	input  mipsIsa_pkg::word_t b,
	input  logic [4:0]         shamt,
	output mipsIsa_pkg::word_t y
);

	always_comb begin
		case (op)
			// addu and subu wrap, no overflow trap
			pipe_pkg::aluAdd: y = a + b;
			pipe_pkg::aluSub: y = a - b;
			pipe_pkg::aluAnd: y = a & b;
			pipe_pkg::aluOr:  y = a | b;
			pipe_pkg::aluXor: y = a ^ b;
			// signed compare
			pipe_pkg::aluSlt: y = {31'b0, $signed(a) < $signed(b)};
			// shift amount from the instruction, shifts rt
			pipe_pkg::aluSll: y = b << shamt;
			// immediate into upper half
			pipe_pkg::aluLui: y = {b[15:0], 16'h0000};
			default:          y = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  mipsIsa_pkg::regAddr_t decRs,
	input  mipsIsa_pkg::regAddr_t decRt,
	input  pipe_pkg::decToExec_t  exec,
	input  pipe_pkg::execToMem_t  mem,
	input  pipe_pkg::memToWb_t    wb,
	output logic [1:0]            fwdA,
	output logic [1:0]            fwdB,
	output logic                  stall,
	output logic                  flushExec
);

	logic loadUse;

	// memory stage wins, it holds the younger result
	function automatic logic [1:0] pickFwd(
		input mipsIsa_pkg::regAddr_t src,
		input pipe_pkg::execToMem_t  m,
		input pipe_pkg::memToWb_t    w
	);
		if (src == '0) begin
			return pipe_pkg::fwdNone;
		end else if (m.regWrite && m.dest == src) begin
			return pipe_pkg::fwdMem;
		end else if (w.regWrite && w.dest == src) begin
			return pipe_pkg::fwdWb;
		end
		return pipe_pkg::fwdNone;
	endfunction

	// ==============================
	// forwarding into execute
	// ==============================
	assign fwdA = pickFwd(exec.rs, mem, wb);
	assign fwdB = pickFwd(exec.rt, mem, wb);

	// ==============================
	// load-use
	// ==============================
	// load data only exists in writeback, hold decode one cycle
	assign loadUse = (exec.loadWidth != pipe_pkg::memNone) && exec.regWrite &&
		(exec.dest != '0) && (exec.dest == decRs || exec.dest == decRt);

	// fetch and decode freeze, execute gets a bubble
	assign stall     = loadUse;
	assign flushExec = loadUse;

endmodule

`default_nettype wire

// File: rtl/memAlign.sv
`timescale 1ns/1ps
`default_nettype none

module memAlign (
	// store side, memory stage
	input  mipsIsa_pkg::word_t    addr,
	input  pipe_pkg::memWidth_t   storeWidth,
	input  mipsIsa_pkg::word_t    storeData,
	output logic [3:0]            byteEn,
	output mipsIsa_pkg::word_t    wrData,
	// load side, writeback stage
	input  logic [1:0]            loadAddrLow,
	input  pipe_pkg::memWidth_t   loadWidth,
	input  logic                  loadSigned,
	input  mipsIsa_pkg::word_t    rawData,
	output mipsIsa_pkg::word_t    loadData
);

	logic [7:0]  byteLane;
	logic [15:0] halfLane;

	// ==============================
	// store
	// ==============================
	// data repeated on every lane, enables pick the lane
	always_comb begin
		case (storeWidth)
			pipe_pkg::memByte: begin
				wrData = {4{storeData[7:0]}};
				byteEn = 4'b0001 << addr[1:0];
			end
			pipe_pkg::memHalf: begin
				wrData = {2{storeData[15:0]}};
				byteEn = addr[1] ? 4'b1100 : 4'b0011;
			end
			pipe_pkg::memWord: begin
				wrData = storeData;
				byteEn = 4'b1111;
			end
			default: begin
				// no store, nothing enabled
				wrData = storeData;
				byteEn = 4'b0000;
			end
		endcase
	end

	// ==============================
	// load
	// ==============================
	// little endian lane select
	assign byteLane = rawData[8*loadAddrLow +: 8];
	assign halfLane = loadAddrLow[1] ? rawData[31:16] : rawData[15:0];

	always_comb begin
		case (loadWidth)
			pipe_pkg::memByte: loadData = {{24{loadSigned & byteLane[7]}}, byteLane};
			pipe_pkg::memHalf: loadData = {{16{loadSigned & halfLane[15]}}, halfLane};
			// word and non-loads pass through
			default:           loadData = rawData;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  logic                  clk,
	input  logic                  arstN,
	// instruction memory
	output mipsIsa_pkg::word_t    pcF,
	input  mipsIsa_pkg::word_t    instrF,
	// data memory
	output mipsIsa_pkg::word_t    dataAddr,
	output mipsIsa_pkg::word_t    dataWrData,
	output logic [3:0]            dataByteEn,
	input  mipsIsa_pkg::word_t    dataRdData,
	// retire
	output logic                  wbEn,
	output mipsIsa_pkg::regAddr_t wbReg,
	output mipsIsa_pkg::word_t    wbData,
	output mipsIsa_pkg::word_t    wbPc
);

	mipsIsa_pkg::word_t    pcPlus4;
	pipe_pkg::fetchToDec_t decIn;
	pipe_pkg::fetchToDec_t decQ;
	pipe_pkg::decToExec_t  decCtrl;
	pipe_pkg::decToExec_t  execIn;
	pipe_pkg::decToExec_t  execQ;
	pipe_pkg::execToMem_t  memIn;
	pipe_pkg::execToMem_t  memQ;
	pipe_pkg::memToWb_t    wbIn;
	pipe_pkg::memToWb_t    wbQ;
	mipsIsa_pkg::word_t    rfDataA;
	mipsIsa_pkg::word_t    rfDataB;
	mipsIsa_pkg::word_t    srcA;
	mipsIsa_pkg::word_t    srcB;
	mipsIsa_pkg::word_t    aluB;
	mipsIsa_pkg::word_t    aluY;
	mipsIsa_pkg::word_t    loadData;
	mipsIsa_pkg::word_t    wbResult;
	logic [1:0]            fwdA;
	logic [1:0]            fwdB;
	logic                  stall;
	logic                  flushExec;

	// operand pick for execute
	function automatic mipsIsa_pkg::word_t fwdMux(
		input logic [1:0]         sel,
		input mipsIsa_pkg::word_t regVal,
		input mipsIsa_pkg::word_t memVal,
		input mipsIsa_pkg::word_t wbVal
	);
		case (sel)
			pipe_pkg::fwdMem: return memVal;
			pipe_pkg::fwdWb:  return wbVal;
			default:          return regVal;
		endcase
	endfunction

	// ==============================
	// fetch
	// ==============================
	// pc held during a load-use stall
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= mipsIsa_pkg::resetVector;
		end else if (!stall) begin
			pcF <= pcPlus4;
		end
	end

	assign pcPlus4     = pcF + 32'd4;
	assign decIn.instr = instrF;
	assign decIn.pc    = pcF;

	stageReg #(.payload_t(pipe_pkg::fetchToDec_t)) u_decReg (
		.clk(clk), .arstN(arstN), .en(!stall), .clr(1'b0), .d(decIn), .q(decQ)
	);

	// ==============================
	// decode
	// ==============================
	instrDecoder u_decoder (
		.instr(decQ.instr),
		.ctrl (decCtrl)
	);

	// reads come from the decoder's source fields
	// writeback port drives the same-cycle bypass
	regFile u_regFile (
		.clk    (clk),
		.arstN  (arstN),
		.rdAddrA(decCtrl.rs),
		.rdAddrB(decCtrl.rt),
		.rdDataA(rfDataA),
		.rdDataB(rfDataB),
		.wrEn   (wbQ.regWrite),
		.wrAddr (wbQ.dest),
		.wrData (wbResult)
	);

	// decoder leaves operands and pc empty
	always_comb begin
		execIn     = decCtrl;
		execIn.opA = rfDataA;
		execIn.opB = rfDataB;
		execIn.pc  = decQ.pc;
	end

	hazardUnit u_hazard (
		.decRs    (decCtrl.rs),
		.decRt    (decCtrl.rt),
		.exec     (execQ),
		.mem      (memQ),
		.wb       (wbQ),
		.fwdA     (fwdA),
		.fwdB     (fwdB),
		.stall    (stall),
		.flushExec(flushExec)
	);

	stageReg #(.payload_t(pipe_pkg::decToExec_t)) u_execReg (
		.clk(clk), .arstN(arstN), .en(1'b1), .clr(flushExec), .d(execIn), .q(execQ)
	);

	// ==============================
	// execute
	// ==============================
	// memory forwards the alu result, writeback the filtered result
	assign srcA = fwdMux(fwdA, execQ.opA, memQ.aluResult, wbResult);
	assign srcB = fwdMux(fwdB, execQ.opB, memQ.aluResult, wbResult);
	assign aluB = execQ.immSel ? execQ.imm : srcB;

	alu u_alu (
		.op   (execQ.aluOp),
		.a    (srcA),
		.b    (aluB),
		.shamt(execQ.shamt),
		.y    (aluY)
	);

	always_comb begin
		memIn.aluResult  = aluY;
		// forwarded rt is the store data
		memIn.storeData  = srcB;
		memIn.dest       = execQ.dest;
		memIn.regWrite   = execQ.regWrite;
		memIn.loadWidth  = execQ.loadWidth;
		memIn.loadSigned = execQ.loadSigned;
		memIn.storeWidth = execQ.storeWidth;
		memIn.pc         = execQ.pc;
	end

	stageReg #(.payload_t(pipe_pkg::execToMem_t)) u_memReg (
		.clk(clk), .arstN(arstN), .en(1'b1), .clr(1'b0), .d(memIn), .q(memQ)
	);

	// ==============================
	// memory and writeback
	// ==============================
	assign dataAddr = memQ.aluResult;

	// store lanes in memory, load filter in writeback
	memAlign u_memAlign (
		.addr       (memQ.aluResult),
		.storeWidth (memQ.storeWidth),
		.storeData  (memQ.storeData),
		.byteEn     (dataByteEn),
		.wrData     (dataWrData),
		.loadAddrLow(wbQ.aluResult[1:0]),
		.loadWidth  (wbQ.loadWidth),
		.loadSigned (wbQ.loadSigned),
		.rawData    (wbQ.rdData),
		.loadData   (loadData)
	);

	always_comb begin
		wbIn.aluResult  = memQ.aluResult;
		// raw word, lane picked next stage
		wbIn.rdData     = dataRdData;
		wbIn.dest       = memQ.dest;
		wbIn.regWrite   = memQ.regWrite;
		wbIn.loadWidth  = memQ.loadWidth;
		wbIn.loadSigned = memQ.loadSigned;
		wbIn.pc         = memQ.pc;
	end

	stageReg #(.payload_t(pipe_pkg::memToWb_t)) u_wbReg (
		.clk(clk), .arstN(arstN), .en(1'b1), .clr(1'b0), .d(wbIn), .q(wbQ)
	);

	// loads take the filtered word
	assign wbResult = (wbQ.loadWidth != pipe_pkg::memNone) ? loadData : wbQ.aluResult;

	// retire port
	assign wbEn   = wbQ.regWrite;
	assign wbReg  = wbQ.dest;
	assign wbData = wbResult;
	assign wbPc   = wbQ.pc;

endmodule

`default_nettype wire

// File: verif/datapath_props.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_props (
	input logic                  clk,
	input logic                  arstN,
	input mipsIsa_pkg::word_t    pcF,
	input mipsIsa_pkg::word_t    dataAddr,
	input mipsIsa_pkg::word_t    dataWrData,
	input logic [3:0]            dataByteEn,
	input logic                  wbEn,
	input mipsIsa_pkg::regAddr_t wbReg
);

	// cycles since reset release, saturating
	logic [2:0] sinceReset;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			sinceReset <= '0;
		end else if (sinceReset != 3'd7) begin
			sinceReset <= sinceReset + 3'd1;
		end
	end

	// ==============================
	// reset quiet
	// ==============================
	// first store can reach memory one cycle before the first retire
	quietRetire: assert property (@(posedge clk) (sinceReset < 3'd4) |-> !wbEn)
		else $error("retire seen during or just after reset");
	quietStore: assert property (@(posedge clk) (sinceReset < 3'd3) |-> (dataByteEn == 4'b0000))
		else $error("store enable seen during or just after reset");

	// ==============================
	// fetch progress
	// ==============================
	pcStep: assert property (@(posedge clk) disable iff (!arstN)
		(sinceReset >= 3'd2) |-> (pcF == $past(pcF) + 32'd4 || pcF == $past(pcF)))
		else $error("pc neither held nor advanced by 4");
	// load-use costs exactly one cycle
	pcHoldOnce: assert property (@(posedge clk) disable iff (!arstN)
		(sinceReset >= 3'd2 && pcF == $past(pcF)) |=> (pcF == $past(pcF) + 32'd4))
		else $error("pc held for more than one cycle");

	// ==============================
	// store lanes
	// ==============================
	enLegal: assert property (@(posedge clk) disable iff (!arstN)
		dataByteEn inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111})
		else $error("illegal byte enable pattern");
	// byte repeated on all lanes, enable at the address lane
	byteLane: assert property (@(posedge clk) disable iff (!arstN)
		$onehot(dataByteEn) |->
			(dataByteEn == (4'b0001 << dataAddr[1:0]) && dataWrData == {4{dataWrData[7:0]}}))
		else $error("byte store lane or data wrong");
	halfLane: assert property (@(posedge clk) disable iff (!arstN)
		(dataByteEn == 4'b0011 || dataByteEn == 4'b1100) |->
			(dataByteEn[2] == dataAddr[1] && dataWrData[31:16] == dataWrData[15:0]))
		else $error("halfword store lane or data wrong");
	wordLane: assert property (@(posedge clk) disable iff (!arstN)
		(dataByteEn == 4'b1111) |-> (dataAddr[1:0] == 2'b00))
		else $error("word store on an unaligned address");

	// r0 never retires
	noZeroRetire: assert property (@(posedge clk) disable iff (!arstN)
		wbEn |-> (wbReg != '0))
		else $error("retire names register 0");

endmodule

bind datapath datapath_props u_props (
	.clk       (clk),
	.arstN     (arstN),
	.pcF       (pcF),
	.dataAddr  (dataAddr),
	.dataWrData(dataWrData),
	.dataByteEn(dataByteEn),
	.wbEn      (wbEn),
	.wbReg     (wbReg)
);

`default_nettype wire

// File: verif/datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_tb;

	// ==============================
	// sizes and timing
	// ==============================
	localparam int romWords    = 256;
	localparam int ramWords    = 64;
	localparam int progLen     = 200;
	localparam int resetCycles = 16;
	// every fetch stalling once, doubled for margin
	localparam int watchdogCycles = 2 * (resetCycles + 2 * romWords);
	// first fetch address past the rom
	localparam mipsIsa_pkg::word_t romEnd = 32'(romWords * 4);

	// one expected retire
	typedef struct packed {
		mipsIsa_pkg::regAddr_t dest;
		mipsIsa_pkg::word_t    data;
		mipsIsa_pkg::word_t    pc;
	} retire_t;

	logic                  clk;
	logic                  arstN;
	mipsIsa_pkg::word_t    pcF;
	mipsIsa_pkg::word_t    instrF;
	mipsIsa_pkg::word_t    dataAddr;
	mipsIsa_pkg::word_t    dataWrData;
	logic [3:0]            dataByteEn;
	mipsIsa_pkg::word_t    dataRdData;
	logic                  wbEn;
	mipsIsa_pkg::regAddr_t wbReg;
	mipsIsa_pkg::word_t    wbData;
	mipsIsa_pkg::word_t    wbPc;

	mipsIsa_pkg::word_t rom      [romWords];
	mipsIsa_pkg::word_t ram      [ramWords];
	mipsIsa_pkg::word_t ramImage [ramWords];
	mipsIsa_pkg::word_t modelRam [ramWords];
	mipsIsa_pkg::word_t modelReg [32];
	retire_t            expected [$];
	integer             seed;

	datapath u_dut (
		.clk       (clk),
		.arstN     (arstN),
		.pcF       (pcF),
		.instrF    (instrF),
		.dataAddr  (dataAddr),
		.dataWrData(dataWrData),
		.dataByteEn(dataByteEn),
		.dataRdData(dataRdData),
		.wbEn      (wbEn),
		.wbReg     (wbReg),
		.wbData    (wbData),
		.wbPc      (wbPc)
	);

	always #2 clk = ~clk;

	// ==============================
	// memory models
	// ==============================
	// no-ops past the end of the rom
	assign instrF     = (pcF < romEnd) ? rom[pcF[9:2]] : '0;
	assign dataRdData = ram[dataAddr[7:2]];

	function automatic mipsIsa_pkg::word_t mergeBytes(
		input mipsIsa_pkg::word_t old,
		input mipsIsa_pkg::word_t data,
		input logic [3:0]         en
	);
		mipsIsa_pkg::word_t merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (en[b]) begin
				merged[8*b +: 8] = data[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// image reloaded while in reset, byte writes afterwards
	always @(posedge clk) begin
		if (!arstN) begin
			ram <= ramImage;
		end else if (dataByteEn != 4'b0000) begin
			ram[dataAddr[7:2]] <= mergeBytes(ram[dataAddr[7:2]], dataWrData, dataByteEn);
		end
	end

	// ==============================
	// program generation
	// ==============================
	function automatic mipsIsa_pkg::word_t rType(
		input logic [4:0] rs,
		input logic [4:0] rt,
		input logic [4:0] rd,
		input logic [4:0] shamt,
		input logic [5:0] funct
	);
		return {mipsIsa_pkg::opSpecial, rs, rt, rd, shamt, funct};
	endfunction

	function automatic mipsIsa_pkg::word_t iType(
		input logic [5:0]  op,
		input logic [4:0]  rs,
		input logic [4:0]  rt,
		input logic [15:0] imm
	);
		return {op, rs, rt, imm};
	endfunction

	// registers 0 to 7 only, so dependencies are dense
	task automatic makeInstr(output mipsIsa_pkg::word_t instr);
		logic [3:0]  kind;
		logic [2:0]  sel;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [7:0]  off;
		kind = 4'($unsigned($random(seed)) % 15);
		sel  = 3'($unsigned($random(seed)) % 5);
		rs   = 5'($unsigned($random(seed)) % 8);
		rt   = 5'($unsigned($random(seed)) % 8);
		rd   = 5'($unsigned($random(seed)) % 8);
		imm  = 16'($random(seed));
		off  = 8'($random(seed));
		case (kind)
			4'd0: instr = rType(rs, rt, rd, 5'd0, mipsIsa_pkg::fnAddu);
			4'd1: instr = rType(rs, rt, rd, 5'd0, mipsIsa_pkg::fnSubu);
			4'd2: instr = rType(rs, rt, rd, 5'd0, mipsIsa_pkg::fnAnd);
			4'd3: instr = rType(rs, rt, rd, 5'd0, mipsIsa_pkg::fnOr);
			4'd4: instr = rType(rs, rt, rd, 5'd0, mipsIsa_pkg::fnXor);
			4'd5: instr = rType(rs, rt, rd, 5'd0, mipsIsa_pkg::fnSlt);
			4'd6: instr = rType(5'd0, rt, rd, imm[4:0], mipsIsa_pkg::fnSll);
			4'd7: instr = iType(mipsIsa_pkg::opAddiu, rs, rt, imm);
			4'd8: instr = iType(mipsIsa_pkg::opOri, rs, rt, imm);
			4'd9: instr = iType(mipsIsa_pkg::opLui, 5'd0, rt, imm);
			// loads off r0, offset aligned to the width
			4'd10, 4'd11, 4'd12: begin
				case (sel)
					3'd0: instr = iType(mipsIsa_pkg::opLb, 5'd0, rt, {8'h00, off});
					3'd1: instr = iType(mipsIsa_pkg::opLbu, 5'd0, rt, {8'h00, off});
					3'd2: instr = iType(mipsIsa_pkg::opLh, 5'd0, rt, {8'h00, off & 8'hfe});
					3'd3: instr = iType(mipsIsa_pkg::opLhu, 5'd0, rt, {8'h00, off & 8'hfe});
					default: instr = iType(mipsIsa_pkg::opLw, 5'd0, rt, {8'h00, off & 8'hfc});
				endcase
			end
			// stores, rt is the data
			default: begin
				case (sel)
					3'd0, 3'd1: instr = iType(mipsIsa_pkg::opSb, 5'd0, rt, {8'h00, off});
					3'd2, 3'd3: instr = iType(mipsIsa_pkg::opSh, 5'd0, rt, {8'h00, off & 8'hfe});
					default:    instr = iType(mipsIsa_pkg::opSw, 5'd0, rt, {8'h00, off & 8'hfc});
				endcase
			end
		endcase
	endtask

	// ==============================
	// reference model
	// ==============================
	// in-order isa model, one instruction per call
	task automatic modelStep(input mipsIsa_pkg::word_t instr, input mipsIsa_pkg::word_t pc);
		logic [5:0]            op;
		logic [5:0]            funct;
		mipsIsa_pkg::regAddr_t rt;
		mipsIsa_pkg::regAddr_t target;
		mipsIsa_pkg::word_t    a;
		mipsIsa_pkg::word_t    b;
		mipsIsa_pkg::word_t    immS;
		mipsIsa_pkg::word_t    addr;
		mipsIsa_pkg::word_t    word;
		mipsIsa_pkg::word_t    result;
		logic [7:0]            byteVal;
		logic [15:0]           halfVal;
		logic                  writes;
		retire_t               entry;
		op      = instr[31:26];
		funct   = instr[5:0];
		rt      = instr[20:16];
		a       = modelReg[instr[25:21]];
		b       = modelReg[rt];
		immS    = {{16{instr[15]}}, instr[15:0]};
		addr    = a + immS;
		word    = modelRam[addr[7:2]];
		byteVal = word[8*addr[1:0] +: 8];
		halfVal = addr[1] ? word[31:16] : word[15:0];
		target  = rt;
		writes  = 1'b1;
		result  = '0;
		case (op)
			mipsIsa_pkg::opSpecial: begin
				target = instr[15:11];
				case (funct)
					mipsIsa_pkg::fnAddu: result = a + b;
					mipsIsa_pkg::fnSubu: result = a - b;
					mipsIsa_pkg::fnAnd:  result = a & b;
					mipsIsa_pkg::fnOr:   result = a | b;
					mipsIsa_pkg::fnXor:  result = a ^ b;
					mipsIsa_pkg::fnSlt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mipsIsa_pkg::fnSll:  result = b << instr[10:6];
					default:             writes = 1'b0;
				endcase
			end
			mipsIsa_pkg::opAddiu: result = a + immS;
			mipsIsa_pkg::opOri:   result = a | {16'h0000, instr[15:0]};
			mipsIsa_pkg::opLui:   result = {instr[15:0], 16'h0000};
			mipsIsa_pkg::opLb:    result = {{24{byteVal[7]}}, byteVal};
			mipsIsa_pkg::opLbu:   result = {24'h000000, byteVal};
			mipsIsa_pkg::opLh:    result = {{16{halfVal[15]}}, halfVal};
			mipsIsa_pkg::opLhu:   result = {16'h0000, halfVal};
			mipsIsa_pkg::opLw:    result = word;
			mipsIsa_pkg::opSb: begin
				writes = 1'b0;
				word[8*addr[1:0] +: 8] = b[7:0];
				modelRam[addr[7:2]] = word;
			end
			mipsIsa_pkg::opSh: begin
				writes = 1'b0;
				if (addr[1]) begin
					word[31:16] = b[15:0];
				end else begin
					word[15:0] = b[15:0];
				end
				modelRam[addr[7:2]] = word;
			end
			mipsIsa_pkg::opSw: begin
				writes = 1'b0;
				modelRam[addr[7:2]] = b;
			end
			default: writes = 1'b0;
		endcase
		// r0 writes vanish and never retire
		if (writes && target != '0) begin
			modelReg[target] = result;
			entry.dest = target;
			entry.data = result;
			entry.pc   = pc;
			expected.push_back(entry);
		end
	endtask

	task automatic buildProgram();
		for (int i = 0; i < romWords; i++) begin
			if (i < progLen) begin
				makeInstr(rom[i]);
			end else begin
				rom[i] = '0;
			end
		end
		// fill depends on the whole word index
		for (int i = 0; i < ramWords; i++) begin
			ramImage[i] = 32'(i + 1) * 32'h9e37_79b9;
			modelRam[i] = ramImage[i];
		end
		for (int r = 0; r < 32; r++) begin
			modelReg[r] = '0;
		end
		for (int i = 0; i < romWords; i++) begin
			modelStep(rom[i], 32'(i * 4));
		end
	endtask

	// ==============================
	// checking
	// ==============================
	task automatic stopOnFailure(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic checkRetire();
		retire_t head;
		assert (expected.size() != 0) else
			stopOnFailure($sformatf("Fail at %0t: r%0d retired at pc %h, nothing left to retire",
				$time, wbReg, wbPc));
		head = expected.pop_front();
		assert (wbReg == head.dest && wbData == head.data && wbPc == head.pc) else
			stopOnFailure($sformatf("Fail at %0t: got pc %h r%0d = %h, expected pc %h r%0d = %h",
				$time, wbPc, wbReg, wbData, head.pc, head.dest, head.data));
	endtask

	// mid-cycle, outputs settled
	always @(negedge clk) begin
		if (arstN && wbEn) begin
			checkRetire();
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		stopOnFailure($sformatf("Watchdog expired after %0d cycles, the program did not finish",
			watchdogCycles));
	end

	// ==============================
	// main sequence
	// ==============================
	initial begin
		$timeformat(-9, 0, " ns", 0);
		clk   = 1'b0;
		arstN = 1'b0;
		seed  = 60;
		buildProgram();
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		// whole rom fetched and every expected retire seen
		do begin
			@(negedge clk);
		end while (expected.size() != 0 || pcF < romEnd);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: datapath.f
rtl/mipsIsa_pkg.sv
rtl/pipe_pkg.sv
rtl/stageReg.sv
rtl/regFile.sv
rtl/instrDecoder.sv
rtl/alu.sv
rtl/hazardUnit.sv
rtl/memAlign.sv
rtl/datapath.sv
verif/datapath_props.sv
verif/datapath_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= datapath_tb
FILELIST  ?= datapath.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Checks failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	@./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
